// File: include/divider_settings.svh
`ifndef DIVIDER_SETTINGS_SVH
`define DIVIDER_SETTINGS_SVH

// data word width
`define DIV_XLEN 32

// operation codes, low two bits of funct3
`define DIV_OP_DIV  2'd0
`define DIV_OP_DIVU 2'd1
`define DIV_OP_REM  2'd2
`define DIV_OP_REMU 2'd3

// opcode bit meanings
`define DIV_OP_UNS_BIT 0
`define DIV_OP_REM_BIT 1

// quotient bits retired per step, and steps between pipeline registers
`define DIV_RADIX_BITS      4
`define DIV_STEPS_PER_STAGE 2

// result buffer entries
`define DIV_FIFO_DEPTH 4

`endif

// File: src/div_pkg.sv
`include "divider_settings.svh"

package div_pkg;

    // sideband carried alongside each divide through the core
    localparam int DIV_SIDE_W = 4;

    // sideband bit positions
    localparam int SIDE_REM_SEL  = 0;
    localparam int SIDE_NEG_QUO  = 1;
    localparam int SIDE_NEG_REM  = 2;
    localparam int SIDE_DIV_ZERO = 3;

    // working word of the restoring divider
    // raw view is the whole shift register
    // pair view splits it into partial remainder and dividend bits not yet consumed
    typedef union packed {
        logic [2*`DIV_XLEN-1:0] raw;
        struct packed {
            logic [`DIV_XLEN-1:0] part_rem;
            logic [`DIV_XLEN-1:0] pend;
        } pair;
    } div_work_u;

endpackage

// File: src/div_operand_stage.sv
`timescale 1ns/1ps
`include "divider_settings.svh"

module div_operand_stage
    import div_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    input  logic [1:0]            in_op,
    input  logic [`DIV_XLEN-1:0]  in_rs1,
    input  logic [`DIV_XLEN-1:0]  in_rs2,
    input  logic                  slot_free,
    output logic                  in_ack,
    output logic                  issue_valid,
    output logic [`DIV_XLEN-1:0]  issue_dividend,
    output logic [`DIV_XLEN-1:0]  issue_divisor,
    output logic [DIV_SIDE_W-1:0] issue_side
);

    localparam int XLEN = `DIV_XLEN;

    logic                  ack_prev;
    logic                  accept;
    logic                  is_uns;
    logic                  rs1_neg;
    logic                  rs2_neg;
    logic                  div_zero;
    logic [XLEN-1:0]       rs1_mag;
    logic [XLEN-1:0]       rs2_mag;
    logic [DIV_SIDE_W-1:0] side_next;

    // accept only on a fresh request with a result slot reserved for it
    assign accept = in_req & ~in_ack & ~ack_prev & slot_free;

    // handshake control
    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack      <= 1'b0;
            ack_prev    <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            ack_prev    <= in_ack;
            issue_valid <= accept;
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
        end
    end

    // signed operands become magnitudes, most negative value maps onto itself
    assign is_uns   = in_op[`DIV_OP_UNS_BIT];
    assign rs1_neg  = ~is_uns & in_rs1[XLEN-1];
    assign rs2_neg  = ~is_uns & in_rs2[XLEN-1];
    assign rs1_mag  = rs1_neg ? -in_rs1 : in_rs1;
    assign rs2_mag  = rs2_neg ? -in_rs2 : in_rs2;
    assign div_zero = (in_rs2 == '0);

    always_comb begin
        side_next = '0;
        side_next[SIDE_REM_SEL]  = in_op[`DIV_OP_REM_BIT];
        // quotient of x/0 stays all ones regardless of signs
        side_next[SIDE_NEG_QUO]  = (rs1_neg ^ rs2_neg) & ~div_zero;
        // remainder follows the dividend sign
        side_next[SIDE_NEG_REM]  = rs1_neg;
        side_next[SIDE_DIV_ZERO] = div_zero;
    end

    // issue bus payload
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_dividend <= rs1_mag;
            issue_divisor  <= rs2_mag;
            issue_side     <= side_next;
        end
    end

endmodule

// File: src/div_radix16_core.sv
`timescale 1ns/1ps
`include "divider_settings.svh"

module div_radix16_core
    import div_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  logic [`DIV_XLEN-1:0]  issue_dividend,
    input  logic [`DIV_XLEN-1:0]  issue_divisor,
    input  logic [DIV_SIDE_W-1:0] issue_side,
    output logic                  core_valid,
    output logic [`DIV_XLEN-1:0]  core_quot,
    output logic [`DIV_XLEN-1:0]  core_rem,
    output logic [DIV_SIDE_W-1:0] core_side
);

    localparam int XLEN   = `DIV_XLEN;
    localparam int RB     = `DIV_RADIX_BITS;
    localparam int SPS    = `DIV_STEPS_PER_STAGE;
    localparam int NSTEP  = XLEN / RB;
    localparam int NSTAGE = NSTEP / SPS;
    localparam int MW     = XLEN + RB;
    localparam int NMULT  = 2**RB - 1;

    // stage 0 works straight off the issue bus
    // every later stage starts from a register, and the output register closes
    // the last one, so latency is NSTAGE cycles
    for (genvar g = 0; g < NSTAGE; g++) begin : g_stage
        logic                  valid_in;
        logic [DIV_SIDE_W-1:0] side_in;
        logic [MW-1:0]         mult_in [1:NMULT];
        div_work_u             work_in;
        logic [XLEN-1:0]       quot_in;
        div_work_u             work [0:SPS];
        logic [XLEN-1:0]       quot [0:SPS];

        if (g == 0) begin : g_issue
            assign valid_in = issue_valid;
            assign side_in  = issue_side;
            assign work_in.raw = {{XLEN{1'b0}}, issue_dividend};
            assign quot_in  = '0;

            // divisor multiples, built once and carried along with the divide
            for (genvar k = 1; k <= NMULT; k++) begin : g_mult
                assign mult_in[k] = MW'(issue_divisor) * MW'(k);
            end
        end else begin : g_reg
            always_ff @(posedge clk) begin
                if (reset) begin
                    valid_in <= 1'b0;
                end else begin
                    valid_in <= g_stage[g-1].valid_in;
                end
            end

            always_ff @(posedge clk) begin
                side_in <= g_stage[g-1].side_in;
                mult_in <= g_stage[g-1].mult_in;
                work_in <= g_stage[g-1].work[SPS];
                quot_in <= g_stage[g-1].quot[SPS];
            end
        end

        assign work[0] = work_in;
        assign quot[0] = quot_in;

        for (genvar s = 0; s < SPS; s++) begin : g_step
            logic [MW-1:0]   top;
            logic [MW-1:0]   sub;
            logic [RB-1:0]   digit;
            logic [XLEN-1:0] diff;

            // remainder with the next four dividend bits appended
            assign top = {work[s].pair.part_rem, work[s].pair.pend[XLEN-1 -: RB]};

            // multiples rise with k, so the last match is the largest digit
            always_comb begin
                digit = '0;
                sub   = '0;
                for (int k = 1; k <= NMULT; k++) begin
                    if (top >= mult_in[k]) begin
                        digit = RB'(k);
                        sub   = mult_in[k];
                    end
                end
            end

            // new remainder is below the divisor, low word is enough
            assign diff = top[XLEN-1:0] - sub[XLEN-1:0];

            assign work[s+1].raw = {diff, work[s].raw[XLEN-RB-1:0], {RB{1'b0}}};
            assign quot[s+1]     = {quot[s][XLEN-RB-1:0], digit};
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            core_valid <= 1'b0;
        end else begin
            core_valid <= g_stage[NSTAGE-1].valid_in;
        end
    end

    always_ff @(posedge clk) begin
        core_side <= g_stage[NSTAGE-1].side_in;
        core_quot <= g_stage[NSTAGE-1].quot[SPS];
        core_rem  <= g_stage[NSTAGE-1].work[SPS].pair.part_rem;
    end

endmodule

// File: src/div_result_stage.sv
`timescale 1ns/1ps
`include "divider_settings.svh"

module div_result_stage
    import div_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  logic                  core_valid,
    input  logic [`DIV_XLEN-1:0]  core_quot,
    input  logic [`DIV_XLEN-1:0]  core_rem,
    input  logic [DIV_SIDE_W-1:0] core_side,
    input  logic                  out_ack,
    output logic                  slot_free,
    output logic                  out_req,
    output logic [`DIV_XLEN-1:0]  out_result
);

    localparam int XLEN  = `DIV_XLEN;
    localparam int DEPTH = `DIV_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    logic [XLEN-1:0] sel_val;
    logic            negate;
    logic            fix_valid;
    logic [XLEN-1:0] fix_data;
    logic [XLEN-1:0] mem [0:DEPTH-1];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   fifo_count;
    logic [CW-1:0]   reserved;
    logic            ack_wait;
    logic            pop;

    // pick the result and restore its sign
    assign sel_val = core_side[SIDE_REM_SEL] ? core_rem : core_quot;
    assign negate  = core_side[SIDE_REM_SEL] ? core_side[SIDE_NEG_REM]
                                             : core_side[SIDE_NEG_QUO] & ~core_side[SIDE_DIV_ZERO];

    always_ff @(posedge clk) begin
        if (reset) begin
            fix_valid <= 1'b0;
        end else begin
            fix_valid <= core_valid;
        end
    end

    always_ff @(posedge clk) begin
        fix_data <= negate ? -sel_val : sel_val;
    end

    // result FIFO, never overflows since every entry was reserved at issue
    always_ff @(posedge clk) begin
        if (fix_valid) begin
            mem[wr_ptr] <= fix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (fix_valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({fix_valid, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // credit, counts divides in flight plus buffered results
    always_ff @(posedge clk) begin
        if (reset) begin
            reserved <= '0;
        end else begin
            case ({issue_valid, pop})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

    assign slot_free = (reserved < CW'(DEPTH));

    // output handshake, wait for ack low before the next request
    assign out_req    = (fifo_count != '0) & ~ack_wait;
    assign out_result = mem[rd_ptr];
    assign pop        = out_req & out_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_wait <= 1'b0;
        end else if (pop) begin
            ack_wait <= 1'b1;
        end else if (!out_ack) begin
            ack_wait <= 1'b0;
        end
    end

endmodule

// File: src/div_unit_top.sv
`timescale 1ns/1ps
`include "divider_settings.svh"

module div_unit_top
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    input  logic [1:0]           in_op,
    input  logic [`DIV_XLEN-1:0] in_rs1,
    input  logic [`DIV_XLEN-1:0] in_rs2,
    input  logic                 out_ack,
    output logic                 in_ack,
    output logic                 out_req,
    output logic [`DIV_XLEN-1:0] out_result
);

    logic                  slot_free;
    logic                  issue_valid;
    logic [`DIV_XLEN-1:0]  issue_dividend;
    logic [`DIV_XLEN-1:0]  issue_divisor;
    logic [DIV_SIDE_W-1:0] issue_side;
    logic                  core_valid;
    logic [`DIV_XLEN-1:0]  core_quot;
    logic [`DIV_XLEN-1:0]  core_rem;
    logic [DIV_SIDE_W-1:0] core_side;

    div_operand_stage u_div_operand_stage (
        .clk            (clk),
        .reset          (reset),
        .in_req         (in_req),
        .in_op          (in_op),
        .in_rs1         (in_rs1),
        .in_rs2         (in_rs2),
        .slot_free      (slot_free),
        .in_ack         (in_ack),
        .issue_valid    (issue_valid),
        .issue_dividend (issue_dividend),
        .issue_divisor  (issue_divisor),
        .issue_side     (issue_side)
    );

    div_radix16_core u_div_radix16_core (
        .clk            (clk),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_dividend (issue_dividend),
        .issue_divisor  (issue_divisor),
        .issue_side     (issue_side),
        .core_valid     (core_valid),
        .core_quot      (core_quot),
        .core_rem       (core_rem),
        .core_side      (core_side)
    );

    // issue_valid also books the FIFO slot
    div_result_stage u_div_result_stage (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .core_valid  (core_valid),
        .core_quot   (core_quot),
        .core_rem    (core_rem),
        .core_side   (core_side),
        .out_ack     (out_ack),
        .slot_free   (slot_free),
        .out_req     (out_req),
        .out_result  (out_result)
    );

endmodule

// File: sim/div_unit_tb.sv
`timescale 1ns/1ps
`include "divider_settings.svh"

module div_unit_tb;

    localparam int XLEN       = `DIV_XLEN;
    localparam int DEPTH      = `DIV_FIFO_DEPTH;
    localparam int N_FIXED    = 29;
    localparam int N_SLOW     = 16;
    localparam int N_RAND     = 200;
    localparam int NROWS      = N_FIXED + N_SLOW + N_RAND;
    localparam int TIMEOUT_NS = NROWS * 40 * 8;

    logic            clk;
    logic            reset;
    logic            in_req;
    logic [1:0]      in_op;
    logic [XLEN-1:0] in_rs1;
    logic [XLEN-1:0] in_rs2;
    logic            out_ack;
    logic            in_ack;
    logic            out_req;
    logic [XLEN-1:0] out_result;

    // stimulus table
    logic [1:0]      tab_op  [0:NROWS-1];
    logic [XLEN-1:0] tab_rs1 [0:NROWS-1];
    logic [XLEN-1:0] tab_rs2 [0:NROWS-1];
    logic [XLEN-1:0] tab_exp [0:NROWS-1];
    int              n_rows;
    int              slow_first;
    int              slow_last;

    // rows accepted by the DUT, oldest first
    int              pending [$];

    int              pass_count;
    int              fail_count;
    int              err_count;
    int              done_count;
    int              outstanding;
    int              max_outstanding;
    logic            slow_ack;

    // previous negedge samples for the protocol monitor
    logic            req_q;
    logic            ack_q;
    logic            in_ack_q;
    logic [XLEN-1:0] data_q;

    div_unit_top u_div_unit_top (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .in_op      (in_op),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .out_ack    (out_ack),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_result (out_result)
    );

    always #4 clk = ~clk;

    // RISC-V divide semantics, including x/0 and the signed overflow case
    function automatic logic [XLEN-1:0] model_div(input logic [1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic                   is_rem;
        logic                   is_uns;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        is_rem = op[`DIV_OP_REM_BIT];
        is_uns = op[`DIV_OP_UNS_BIT];
        sa     = a;
        sb     = b;
        if (b == '0) begin
            return is_rem ? a : '1;
        end
        if (is_uns) begin
            return is_rem ? a % b : a / b;
        end
        if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
            return is_rem ? '0 : a;
        end
        return is_rem ? XLEN'(sa % sb) : XLEN'(sa / sb);
    endfunction

    task automatic add_row(input logic [1:0] op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
        tab_op[n_rows]  = op;
        tab_rs1[n_rows] = a;
        tab_rs2[n_rows] = b;
        tab_exp[n_rows] = exp;
        n_rows++;
    endtask

    task automatic add_random_row();
        logic [1:0]      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        op = 2'($urandom);
        a  = $urandom;
        // shifted divisors give a spread of quotient sizes
        b  = $urandom >> ($urandom % XLEN);
        if ($urandom % 4 == 0) begin
            b = -b;
        end
        if ($urandom % 16 == 0) begin
            b = '0;
        end
        add_row(op, a, b, model_div(op, a, b));
    endtask

    task automatic build_table();
        // unsigned
        add_row(`DIV_OP_DIVU, 32'd100, 32'd7, 32'h0000000e);
        add_row(`DIV_OP_REMU, 32'd100, 32'd7, 32'h00000002);
        add_row(`DIV_OP_DIVU, 32'hffffffff, 32'h1, 32'hffffffff);
        add_row(`DIV_OP_REMU, 32'hffffffff, 32'h1, 32'h00000000);
        add_row(`DIV_OP_DIVU, 32'h5, 32'h80000000, 32'h00000000);
        add_row(`DIV_OP_REMU, 32'h5, 32'h80000000, 32'h00000005);
        add_row(`DIV_OP_DIVU, 32'h12345678, 32'h12345678, 32'h00000001);
        add_row(`DIV_OP_REMU, 32'h12345678, 32'h12345678, 32'h00000000);
        add_row(`DIV_OP_DIVU, 32'hffffffff, 32'hfffffffe, 32'h00000001);
        add_row(`DIV_OP_REMU, 32'hffffffff, 32'hfffffffe, 32'h00000001);
        // signed, all four sign combinations of 7 and 2
        add_row(`DIV_OP_DIV, 32'h7, 32'h2, 32'h00000003);
        add_row(`DIV_OP_REM, 32'h7, 32'h2, 32'h00000001);
        add_row(`DIV_OP_DIV, 32'hfffffff9, 32'h2, 32'hfffffffd);
        add_row(`DIV_OP_REM, 32'hfffffff9, 32'h2, 32'hffffffff);
        add_row(`DIV_OP_DIV, 32'h7, 32'hfffffffe, 32'hfffffffd);
        add_row(`DIV_OP_REM, 32'h7, 32'hfffffffe, 32'h00000001);
        add_row(`DIV_OP_DIV, 32'hfffffff9, 32'hfffffffe, 32'h00000003);
        add_row(`DIV_OP_REM, 32'hfffffff9, 32'hfffffffe, 32'hffffffff);
        // divide by zero
        add_row(`DIV_OP_DIV, 32'h12345678, 32'h0, 32'hffffffff);
        add_row(`DIV_OP_DIVU, 32'h12345678, 32'h0, 32'hffffffff);
        add_row(`DIV_OP_REM, 32'h12345678, 32'h0, 32'h12345678);
        add_row(`DIV_OP_REMU, 32'h12345678, 32'h0, 32'h12345678);
        add_row(`DIV_OP_DIV, 32'h80000001, 32'h0, 32'hffffffff);
        add_row(`DIV_OP_REM, 32'h80000001, 32'h0, 32'h80000001);
        // most negative value
        add_row(`DIV_OP_DIV, 32'h80000000, 32'hffffffff, 32'h80000000);
        add_row(`DIV_OP_REM, 32'h80000000, 32'hffffffff, 32'h00000000);
        add_row(`DIV_OP_DIVU, 32'h80000000, 32'hffffffff, 32'h00000000);
        add_row(`DIV_OP_REMU, 32'h80000000, 32'hffffffff, 32'h80000000);
        add_row(`DIV_OP_DIV, 32'h80000000, 32'h2, 32'hc0000000);
        // back-pressure group, answered slowly
        slow_first = n_rows;
        for (int i = 0; i < N_SLOW; i++) begin
            add_random_row();
        end
        slow_last = n_rows - 1;
        for (int i = 0; i < N_RAND; i++) begin
            add_random_row();
        end
    endtask

    task automatic check_result(input int row, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got === exp) begin
            pass_count++;
            $display("ok   row %0d op %0d rs1 %h rs2 %h result %h",
                     row, tab_op[row], tab_rs1[row], tab_rs2[row], got);
        end else begin
            fail_count++;
            $display("FAIL %0t row %0d op %0d rs1 %h rs2 %h got %h expected %h",
                     $time, row, tab_op[row], tab_rs1[row], tab_rs2[row], got, exp);
        end
    endtask

    task automatic check_protocol(input logic req_was, input logic ack_was,
                                  input logic [XLEN-1:0] data_was, input logic req_now,
                                  input logic [XLEN-1:0] data_now);
        if (req_was && !req_now && !ack_was) begin
            err_count++;
            $display("protocol error at %0t: out_req dropped before out_ack was raised",
                     $time);
        end
        if (req_was && req_now && data_now !== data_was) begin
            err_count++;
            $display("protocol error at %0t: out_result changed while out_req was high",
                     $time);
        end
    endtask

    task automatic check_credit(input int count);
        if (count > DEPTH) begin
            err_count++;
            $display("credit error at %0t: %0d requests accepted for %0d result slots",
                     $time, count, DEPTH);
        end
    endtask

    // the DUT is driven 1 ns after posedge and watched on the negedge
    task automatic send_row(input int row);
        in_op  = tab_op[row];
        in_rs1 = tab_rs1[row];
        in_rs2 = tab_rs2[row];
        in_req = 1'b1;
        do @(negedge clk); while (in_ack !== 1'b1);
        pending.push_back(row);
        @(posedge clk);
        #1;
        in_req = 1'b0;
        do @(negedge clk); while (in_ack !== 1'b0);
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_protocol(req_q, ack_q, data_q, out_req, out_result);
            if (in_ack && !in_ack_q) begin
                outstanding++;
            end
            if (req_q && !out_req) begin
                outstanding--;
            end
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            check_credit(outstanding);
        end
        req_q    = out_req;
        ack_q    = out_ack;
        in_ack_q = in_ack;
        data_q   = out_result;
    end

    initial begin : responder
        int              delay;
        int              row;
        logic [XLEN-1:0] got;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            if (out_req === 1'b1 && out_ack === 1'b0) begin
                got   = out_result;
                delay = slow_ack ? 8 + $urandom % 12 : $urandom % 7;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                out_ack = 1'b1;
                do @(negedge clk); while (out_req === 1'b1);
                if (pending.size() == 0) begin
                    err_count++;
                    $display("result %h arrived with no request outstanding", got);
                end else begin
                    row = pending.pop_front();
                    check_result(row, got, tab_exp[row]);
                    done_count++;
                end
                @(posedge clk);
                #1;
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns with %0d of %0d rows answered",
                 TIMEOUT_NS, done_count, n_rows);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7445));
        clk             = 1'b0;
        reset           = 1'b1;
        in_req          = 1'b0;
        in_op           = '0;
        in_rs1          = '0;
        in_rs2          = '0;
        out_ack         = 1'b0;
        slow_ack        = 1'b0;
        req_q           = 1'b0;
        ack_q           = 1'b0;
        in_ack_q        = 1'b0;
        data_q          = '0;
        n_rows          = 0;
        pass_count      = 0;
        fail_count      = 0;
        err_count       = 0;
        done_count      = 0;
        outstanding     = 0;
        max_outstanding = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            slow_ack = (i >= slow_first) && (i <= slow_last);
            send_row(i);
        end
        wait (done_count == n_rows);
        repeat (10) @(posedge clk);
        if (max_outstanding < DEPTH) begin
            err_count++;
            $display("slow acknowledge never filled the result buffer, peak %0d of %0d",
                     max_outstanding, DEPTH);
        end
        $display("rows %0d passed %0d failed %0d other errors %0d",
                 n_rows, pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
src/div_pkg.sv
src/div_operand_stage.sv
src/div_radix16_core.sv
src/div_result_stage.sv
src/div_unit_top.sv
sim/div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/div_pkg.sv
      - src/div_operand_stage.sv
      - src/div_radix16_core.sv
      - src/div_result_stage.sv
      - src/div_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/div_unit_tb.sv
